// File: design/pes_pkg.sv
package pes_pkg;

  // ##################################################
  // time stamp record
  // ##################################################

  typedef enum logic [1:0] {
    TS_NONE    = 2'd0,  // 0F byte, no stamp
    TS_PTS     = 2'd1,
    TS_PTS_DTS = 2'd2
  } ts_kind_t;

  // 77 bits
  typedef struct packed {
    logic [7:0]  stream_id;
    ts_kind_t    kind;
    logic [32:0] pts;
    logic [32:0] dts;
    logic        marker_err;  // some marker bit was 0
  } ts_rec_t;

  // ##################################################
  // stream ids and special bytes
  // ##################################################

  localparam logic [7:0] AV_ID_MIN  = 8'hC0;  // first audio id
  localparam logic [7:0] AV_ID_MAX  = 8'hEF;  // last video id
  localparam logic [7:0] LEN_ID_MIN = 8'hBC;  // lower ids carry no length

  localparam logic [7:0] STUFF_BYTE = 8'hFF;
  localparam logic [7:0] NO_TS_BYTE = 8'h0F;

  // fifo depths, powers of two
  localparam int PAY_FIFO_DEPTH = 16;
  localparam int REC_FIFO_DEPTH = 4;

endpackage

// File: design/start_code_detector.sv
`timescale 1ns/1ns

module start_code_detector (
  input  logic       read_signal,
  input  logic       rst,
  input  logic [7:0] in_data,
  input  logic       take,
  input  logic       hunting,
  output logic       sc_hit,
  output logic [7:0] sc_id
);

  logic [1:0] zero_cnt;   // run of 00 bytes saturating at 2
  logic [1:0] zero_nxt;
  logic       prefix_ok;  // set once 00 00 01 is seen
  logic       step;

  assign step = take && hunting;

  // id byte is reported on the cycle it is accepted
  assign sc_hit = take && prefix_ok;
  assign sc_id  = prefix_ok ? in_data : 8'h00;

  always_comb
  begin
    if (in_data != 8'h00)
      zero_nxt = 2'd0;
    else if (zero_cnt == 2'd2)
      zero_nxt = 2'd2;
    else
      zero_nxt = zero_cnt + 2'd1;
  end

  always_ff @(posedge read_signal)
  begin
    if (rst || !hunting)
    begin
      zero_cnt  <= 2'd0;
      prefix_ok <= 1'b0;
    end
    else if (step)
    begin
      if (prefix_ok)
      begin
        prefix_ok <= 1'b0;  // start over after the id
        zero_cnt  <= zero_nxt;
      end
      else if (in_data == 8'h01 && zero_cnt == 2'd2)
      begin
        prefix_ok <= 1'b1;
        zero_cnt  <= 2'd0;
      end
      else
        zero_cnt <= zero_nxt;
    end
  end

endmodule

// File: design/pes_header_parser.sv
`timescale 1ns/1ns

module pes_header_parser (
  input  logic             read_signal,
  input  logic             rst,
  input  logic [7:0]       in_data,
  input  logic             in_valid,
  output logic             in_ready,
  output logic             hunting,
  input  logic             sc_hit,
  input  logic [7:0]       sc_id,
  output logic             ts_byte_valid,
  output logic [7:0]       ts_byte,
  input  logic             ts_done,
  input  pes_pkg::ts_rec_t ts_rec,
  output logic             pay_wr,
  output logic [7:0]       pay_byte,
  input  logic             pay_full,
  output logic             rec_wr,
  output pes_pkg::ts_rec_t rec_out,
  input  logic             rec_full
);

  typedef enum logic [2:0] {
    ST_HUNT,
    ST_LEN_HI,
    ST_LEN_LO,
    ST_HEADER,
    ST_TS,
    ST_PAYLOAD,
    ST_SKIP
  } state_t;

  state_t      state;
  logic        run;          // low until first cycle out of reset
  logic        take;
  logic        last_byte;
  logic        ts_first;     // first byte that is neither stuffing nor STD
  logic        std_pending;  // second STD byte still to drop
  logic [7:0]  len_hi;
  logic [15:0] count;        // bytes left in the packet
  logic [7:0]  stream_id;

  // ##################################################
  // handshake and routing
  // ##################################################

  assign in_ready  = run && !rec_full && !(state == ST_PAYLOAD && pay_full);
  assign take      = in_valid && in_ready;
  assign hunting   = (state == ST_HUNT);
  assign last_byte = (count == 16'd1);

  assign ts_first = (state == ST_HEADER) && !std_pending &&
                    (in_data != pes_pkg::STUFF_BYTE) && (in_data[7:6] != 2'b01);

  assign ts_byte_valid = take && (ts_first || state == ST_TS);
  assign ts_byte       = in_data;
  assign pay_wr        = take && (state == ST_PAYLOAD);
  assign pay_byte      = in_data;
  assign rec_wr        = ts_done;  // rec_full already holds off take

  always_comb
  begin
    rec_out           = ts_rec;
    rec_out.stream_id = stream_id;
  end

  // ##################################################
  // packet FSM
  // ##################################################

  always_ff @(posedge read_signal)
  begin
    if (rst)
    begin
      state       <= ST_HUNT;
      run         <= 1'b0;
      std_pending <= 1'b0;
      count       <= 16'd0;
    end
    else
    begin
      run <= 1'b1;
      if (take)
      begin
        case (state)
          ST_HUNT:
            if (sc_hit && sc_id >= pes_pkg::LEN_ID_MIN)
            begin
              stream_id <= sc_id;
              state     <= ST_LEN_HI;
            end
          ST_LEN_HI:
          begin
            len_hi <= in_data;
            state  <= ST_LEN_LO;
          end
          ST_LEN_LO:
          begin
            count       <= {len_hi, in_data};
            std_pending <= 1'b0;
            if ({len_hi, in_data} == 16'd0)
              state <= ST_HUNT;  // empty packet
            else if (stream_id >= pes_pkg::AV_ID_MIN && stream_id <= pes_pkg::AV_ID_MAX)
              state <= ST_HEADER;
            else
              state <= ST_SKIP;  // padding, private and the like
          end
          default:
          begin
            count <= count - 16'd1;
            if (last_byte)
              state <= ST_HUNT;
            else if (state == ST_HEADER)
            begin
              if (std_pending)
                std_pending <= 1'b0;
              else if (in_data[7:6] == 2'b01)
                std_pending <= 1'b1;
              if (ts_first)
                state <= ts_done ? ST_PAYLOAD : ST_TS;
            end
            else if (state == ST_TS && ts_done)
              state <= ST_PAYLOAD;
          end
        endcase
      end
    end
  end

endmodule

// File: design/time_stamp_parser.sv
`timescale 1ns/1ns

module time_stamp_parser (
  input  logic             read_signal,
  input  logic             rst,
  input  logic             ts_byte_valid,
  input  logic [7:0]       ts_byte,
  output logic             ts_done,
  output pes_pkg::ts_rec_t ts_rec
);

  logic [3:0]        idx;     // byte number in the field, 0..9
  pes_pkg::ts_kind_t kind_r;
  logic [32:0]       pts_r;
  logic [32:0]       dts_r;
  logic              merr_r;

  pes_pkg::ts_kind_t kind_n;
  logic [32:0]       pts_n;
  logic [32:0]       dts_n;
  logic              merr_n;
  logic [32:0]       cur;     // stamp being filled
  logic [3:0]        grp;     // byte number inside the 5 byte group
  logic              in_dts;
  logic              last;

  // ##################################################
  // byte decode
  // ##################################################

  assign in_dts = (idx >= 4'd5);
  assign grp    = in_dts ? idx - 4'd5 : idx;

  always_comb
  begin
    kind_n = kind_r;
    pts_n  = pts_r;
    dts_n  = dts_r;
    merr_n = merr_r;
    last   = 1'b0;
    cur    = in_dts ? dts_r : pts_r;

    case (grp)
      4'd0:
      begin
        cur[32:30] = ts_byte[3:1];
        merr_n     = merr_r | ~ts_byte[0];
      end
      4'd1: cur[29:22] = ts_byte;
      4'd2:
      begin
        cur[21:15] = ts_byte[7:1];
        merr_n     = merr_r | ~ts_byte[0];
      end
      4'd3: cur[14:7] = ts_byte;
      default:
      begin
        cur[6:0] = ts_byte[7:1];
        merr_n   = merr_r | ~ts_byte[0];
      end
    endcase

    if (in_dts)
      dts_n = cur;
    else
      pts_n = cur;

    // top nibble of the first byte picks the layout
    if (idx == 4'd0)
    begin
      dts_n  = 33'd0;
      merr_n = ~ts_byte[0];
      if (ts_byte[7:4] == 4'b0011)
        kind_n = pes_pkg::TS_PTS_DTS;
      else if (ts_byte[7:4] == 4'b0010)
        kind_n = pes_pkg::TS_PTS;
      else
      begin
        kind_n = pes_pkg::TS_NONE;
        pts_n  = 33'd0;
        merr_n = (ts_byte != pes_pkg::NO_TS_BYTE);  // unknown lead byte
        last   = 1'b1;
      end
    end

    if (idx == 4'd4 && kind_r == pes_pkg::TS_PTS)
      last = 1'b1;
    if (idx == 4'd9)
      last = 1'b1;
  end

  // last byte goes straight into the record
  assign ts_done = ts_byte_valid && last;
  assign ts_rec  = '{stream_id: 8'h00, kind: kind_n, pts: pts_n, dts: dts_n,
                     marker_err: merr_n};

  // ##################################################
  // field registers
  // ##################################################

  always_ff @(posedge read_signal)
  begin
    if (rst)
    begin
      idx    <= 4'd0;
      kind_r <= pes_pkg::TS_NONE;
    end
    else if (ts_byte_valid)
    begin
      idx    <= last ? 4'd0 : idx + 4'd1;
      kind_r <= kind_n;
    end
  end

  always_ff @(posedge read_signal)
  begin
    if (ts_byte_valid)
    begin
      pts_r  <= pts_n;
      dts_r  <= dts_n;
      merr_r <= merr_n;
    end
  end

endmodule

// File: design/sync_fifo.sv
`timescale 1ns/1ns

module sync_fifo #(
  parameter type data_t = logic [7:0],
  parameter int  DEPTH  = 16              // power of two
) (
  input  logic  read_signal,
  input  logic  rst,
  input  logic  wr,
  input  data_t wdata,
  output logic  full,
  output logic  rd_valid,
  input  logic  rd_ready,
  output data_t rdata
);

  data_t                      mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic [$clog2(DEPTH):0]     count;
  logic                       do_wr;
  logic                       do_rd;

  assign full     = (count == ($clog2(DEPTH) + 1)'(DEPTH));
  assign rd_valid = (count != '0);
  assign rdata    = mem[rd_ptr];  // held until popped

  assign do_wr = wr && !full;
  assign do_rd = rd_valid && rd_ready;

  always_ff @(posedge read_signal)
  begin
    if (do_wr)
      mem[wr_ptr] <= wdata;
  end

  always_ff @(posedge read_signal)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;  // wraps at DEPTH
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
      if (do_wr && !do_rd)
        count <= count + 1'b1;
      else if (do_rd && !do_wr)
        count <= count - 1'b1;
    end
  end

endmodule

// File: design/pes_demux_top.sv
`timescale 1ns/1ns

module pes_demux_top (
  input  logic             read_signal,
  input  logic             rst,
  input  logic [7:0]       in_data,
  input  logic             in_valid,
  output logic             in_ready,
  output logic [7:0]       pay_data,
  output logic             pay_valid,
  input  logic             pay_ready,
  output pes_pkg::ts_rec_t rec,
  output logic             rec_valid,
  input  logic             rec_ready
);

  logic             take;
  logic             hunting;
  logic             sc_hit;
  logic [7:0]       sc_id;
  logic             ts_byte_valid;
  logic [7:0]       ts_byte;
  logic             ts_done;
  pes_pkg::ts_rec_t ts_rec;
  logic             pay_wr;
  logic [7:0]       pay_byte;
  logic             pay_full;
  logic             rec_wr;
  pes_pkg::ts_rec_t rec_out;
  logic             rec_full;

  assign take = in_valid && in_ready;

  // ##################################################
  // front end
  // ##################################################

  start_code_detector sc_det (
    .read_signal(read_signal), .rst(rst),
    .in_data(in_data), .take(take), .hunting(hunting),
    .sc_hit(sc_hit), .sc_id(sc_id)
  );

  pes_header_parser hdr_parse (
    .read_signal(read_signal), .rst(rst),
    .in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
    .hunting(hunting), .sc_hit(sc_hit), .sc_id(sc_id),
    .ts_byte_valid(ts_byte_valid), .ts_byte(ts_byte),
    .ts_done(ts_done), .ts_rec(ts_rec),
    .pay_wr(pay_wr), .pay_byte(pay_byte), .pay_full(pay_full),
    .rec_wr(rec_wr), .rec_out(rec_out), .rec_full(rec_full)
  );

  time_stamp_parser ts_parse (
    .read_signal(read_signal), .rst(rst),
    .ts_byte_valid(ts_byte_valid), .ts_byte(ts_byte),
    .ts_done(ts_done), .ts_rec(ts_rec)
  );

  // ##################################################
  // output queues
  // ##################################################

  sync_fifo #(
    .data_t(logic [7:0]),
    .DEPTH (pes_pkg::PAY_FIFO_DEPTH)
  ) pay_fifo (
    .read_signal(read_signal), .rst(rst),
    .wr(pay_wr), .wdata(pay_byte), .full(pay_full),
    .rd_valid(pay_valid), .rd_ready(pay_ready), .rdata(pay_data)
  );

  sync_fifo #(
    .data_t(pes_pkg::ts_rec_t),
    .DEPTH (pes_pkg::REC_FIFO_DEPTH)
  ) rec_fifo (
    .read_signal(read_signal), .rst(rst),
    .wr(rec_wr), .wdata(rec_out), .full(rec_full),
    .rd_valid(rec_valid), .rd_ready(rec_ready), .rdata(rec)
  );

endmodule

// File: tests/clock_gen.sv
`timescale 1ns/1ns

module clock_gen (
  output logic read_signal,
  output logic rst
);

  initial
  begin
    read_signal = 1'b0;
    forever
      #10 read_signal = ~read_signal;  // 20 ns period
  end

  initial
  begin
    rst = 1'b1;
    repeat (3) @(posedge read_signal);
    @(negedge read_signal);
    rst = 1'b0;  // released on a falling edge
  end

endmodule

// File: tests/pes_demux_asserts.sv
`timescale 1ns/1ns

module pes_demux_asserts (
  input logic             read_signal,
  input logic             rst,
  input logic [7:0]       pay_data,
  input logic             pay_valid,
  input logic             pay_ready,
  input pes_pkg::ts_rec_t rec,
  input logic             rec_valid,
  input logic             rec_ready,
  input logic             hunting,
  input logic             sc_hit
);

  // ##################################################
  // output handshakes
  // ##################################################

  pay_hold: assert property (@(posedge read_signal) disable iff (rst)
    (pay_valid && !pay_ready) |=> (pay_valid && $stable(pay_data)))
    else $error("payload valid dropped or data moved before ready");

  rec_hold: assert property (@(posedge read_signal) disable iff (rst)
    (rec_valid && !rec_ready) |=> (rec_valid && $stable(rec)))
    else $error("record valid dropped or record moved before ready");

  // ##################################################
  // reset and start code
  // ##################################################

  reset_quiet: assert property (@(posedge read_signal)
    rst |=> (!pay_valid && !rec_valid))
    else $error("output valid while in reset");

  hit_when_hunting: assert property (@(posedge read_signal) disable iff (rst)
    sc_hit |-> hunting)
    else $error("start code hit outside of hunt");

endmodule

// File: tests/pes_demux_tb.sv
`timescale 1ns/1ns

module pes_demux_tb;

  logic             read_signal;
  logic             rst;
  logic [7:0]       in_data;
  logic             in_valid;
  logic             in_ready;
  logic [7:0]       pay_data;
  logic             pay_valid;
  logic             pay_ready;
  pes_pkg::ts_rec_t rec;
  logic             rec_valid;
  logic             rec_ready;

  logic [7:0]       stream_q[$];   // bytes still to send
  logic [7:0]       exp_pay_q[$];
  pes_pkg::ts_rec_t exp_rec_q[$];

  integer seed;
  bit     rand_mode;   // random gaps and random ready
  bit     gap;
  bit     in_taken;    // byte goes in on the next rising edge
  int     errors;
  int     tests_run;
  int     tests_failed;
  int     total_bytes;
  int     cycles;

  clock_gen clk_gen (.read_signal(read_signal), .rst(rst));

  pes_demux_top dut0 (
    .read_signal(read_signal), .rst(rst),
    .in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
    .pay_data(pay_data), .pay_valid(pay_valid), .pay_ready(pay_ready),
    .rec(rec), .rec_valid(rec_valid), .rec_ready(rec_ready)
  );

  bind pes_demux_top pes_demux_asserts chk (
    .read_signal(read_signal), .rst(rst),
    .pay_data(pay_data), .pay_valid(pay_valid), .pay_ready(pay_ready),
    .rec(rec), .rec_valid(rec_valid), .rec_ready(rec_ready),
    .hunting(hunting), .sc_hit(sc_hit)
  );

  // ##################################################
  // checks
  // ##################################################

  task automatic check_value(input string name, input logic [32:0] got,
                             input logic [32:0] want);
    assert (got === want)
    else
    begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, want);
      errors++;
    end
  endtask

  task automatic take_payload();
    logic [7:0] want;
    assert (exp_pay_q.size() != 0)
    else
    begin
      $display("payload byte %h came out at %0t ns when none was expected", pay_data, $time);
      errors++;
    end
    if (exp_pay_q.size() != 0)
    begin
      want = exp_pay_q.pop_front();
      check_value("pay_data", 33'(pay_data), 33'(want));
    end
  endtask

  task automatic take_record();
    pes_pkg::ts_rec_t want;
    assert (exp_rec_q.size() != 0)
    else
    begin
      $display("record for id %h came out at %0t ns when none was expected",
               rec.stream_id, $time);
      errors++;
    end
    if (exp_rec_q.size() != 0)
    begin
      want = exp_rec_q.pop_front();
      check_value("rec.stream_id", 33'(rec.stream_id), 33'(want.stream_id));
      check_value("rec.kind", 33'(rec.kind), 33'(want.kind));
      check_value("rec.pts", rec.pts, want.pts);
      check_value("rec.dts", rec.dts, want.dts);
      check_value("rec.marker_err", 33'(rec.marker_err), 33'(want.marker_err));
    end
  endtask

  // inputs change and outputs are sampled on the falling edge
  always @(negedge read_signal)
  begin
    if (in_taken)
      void'(stream_q.pop_front());
    gap       = rand_mode && (($random(seed) & 3) == 0);
    in_valid  = (stream_q.size() != 0) && !gap;
    in_data   = in_valid ? stream_q[0] : 8'h00;
    in_taken  = in_valid && in_ready;  // in_ready is registered, stable until the edge
    pay_ready = rand_mode ? (($random(seed) & 1) != 0) : 1'b1;
    rec_ready = rand_mode ? (($random(seed) & 3) == 0) : 1'b1;
    if (!rst)
    begin
      if (pay_valid && pay_ready)
        take_payload();
      if (rec_valid && rec_ready)
        take_record();
    end
  end

  always @(posedge read_signal)
  begin
    cycles++;
    if (cycles > total_bytes * 4 + 200)
    begin
      $display("timeout after %0d cycles, the DUT stopped moving data", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  // ##################################################
  // packet builder
  // ##################################################

  function automatic logic [7:0] payload_pattern(input logic [7:0] id, input int idx);
    return 8'((idx * 29) ^ (idx >> 4) ^ int'(id));
  endfunction

  task automatic push_start_code(input logic [7:0] id);
    stream_q.push_back(8'h00);
    stream_q.push_back(8'h00);
    stream_q.push_back(8'h01);
    stream_q.push_back(id);
  endtask

  // 33 bit stamp in five bytes, markers at bit 0 of bytes 0, 2 and 4
  task automatic push_stamp(input logic [3:0] lead, input logic [32:0] ts, input bit bad);
    stream_q.push_back({lead, ts[32:30], 1'b1});
    stream_q.push_back(ts[29:22]);
    stream_q.push_back({ts[21:15], ~bad});
    stream_q.push_back(ts[14:7]);
    stream_q.push_back({ts[6:0], 1'b1});
  endtask

  task automatic build_packet(input logic [7:0] id, input int n_stuff, input bit with_std,
                              input pes_pkg::ts_kind_t kind, input logic [32:0] pts,
                              input logic [32:0] dts, input int n_pay, input bit bad_marker);
    pes_pkg::ts_rec_t r;
    int               len;
    logic [7:0]       b;
    len = n_stuff + (with_std ? 2 : 0) + n_pay;
    if (kind == pes_pkg::TS_NONE)
      len += 1;
    else if (kind == pes_pkg::TS_PTS)
      len += 5;
    else
      len += 10;
    push_start_code(id);
    stream_q.push_back(8'(len >> 8));
    stream_q.push_back(8'(len));
    repeat (n_stuff) stream_q.push_back(pes_pkg::STUFF_BYTE);
    if (with_std)
    begin
      stream_q.push_back(8'h61);  // 01 scale size
      stream_q.push_back(8'hE8);
    end
    if (kind == pes_pkg::TS_NONE)
      stream_q.push_back(pes_pkg::NO_TS_BYTE);
    else if (kind == pes_pkg::TS_PTS)
      push_stamp(4'b0010, pts, bad_marker);
    else
    begin
      push_stamp(4'b0011, pts, bad_marker);
      push_stamp(4'b0001, dts, 1'b0);
    end
    for (int i = 0; i < n_pay; i++)
    begin
      b = payload_pattern(id, i);
      stream_q.push_back(b);
      exp_pay_q.push_back(b);
    end
    r.stream_id  = id;
    r.kind       = kind;
    r.pts        = (kind == pes_pkg::TS_NONE) ? 33'd0 : pts;
    r.dts        = (kind == pes_pkg::TS_PTS_DTS) ? dts : 33'd0;
    r.marker_err = bad_marker;
    exp_rec_q.push_back(r);
  endtask

  task automatic finish_test(input string name, input int err0);
    total_bytes += stream_q.size();
    while (stream_q.size() != 0 || exp_pay_q.size() != 0 || exp_rec_q.size() != 0)
      @(posedge read_signal);
    repeat (8) @(posedge read_signal);  // room for stray outputs
    tests_run++;
    if (errors == err0)
      $display("%s: passed", name);
    else
    begin
      tests_failed++;
      $display("%s: failed, %0d errors", name, errors - err0);
    end
  endtask

  // ##################################################
  // directed tests
  // ##################################################

  task automatic test_pts_with_std();
    int err0;
    err0 = errors;
    build_packet(8'hE0, 0, 1'b1, pes_pkg::TS_PTS, 33'h1_2345_6789, 33'd0, 20, 1'b0);
    finish_test("1 pts only with std", err0);
  endtask

  task automatic test_pts_dts_stuffing();
    int err0;
    err0 = errors;
    build_packet(8'hE1, 3, 1'b1, pes_pkg::TS_PTS_DTS, 33'h0_ABCD_EF01, 33'h1_0F0F_1234,
                 17, 1'b0);
    finish_test("2 pts and dts with stuffing", err0);
  endtask

  task automatic test_no_stamp();
    int err0;
    err0 = errors;
    build_packet(8'hC2, 0, 1'b0, pes_pkg::TS_NONE, 33'd0, 33'd0, 9, 1'b0);
    finish_test("3 no time stamp", err0);
  endtask

  task automatic test_skip_other_streams();
    int err0;
    err0 = errors;
    stream_q = '{8'h47, 8'h00, 8'h12, 8'h00, 8'h00, 8'h33, 8'hA5, 8'h00};  // garbage
    push_start_code(8'hBE);  // padding, holds a fake start code
    stream_q = {stream_q, 8'h00, 8'h08, 8'h00, 8'h00, 8'h01, 8'hC0, 8'h00, 8'h05,
                8'hFF, 8'hFF};
    push_start_code(8'hBA);  // pack header
    stream_q = {stream_q, 8'h21, 8'h00, 8'h01, 8'h00, 8'h01, 8'h80, 8'h00, 8'h01};
    build_packet(8'hC0, 1, 1'b1, pes_pkg::TS_PTS, 33'h0_0001_2345, 33'd0, 12, 1'b0);
    finish_test("4 garbage, padding and pack header", err0);
  endtask

  task automatic test_back_pressure();
    int err0;
    err0      = errors;
    rand_mode = 1'b1;
    build_packet(8'hE0, 0, 1'b1, pes_pkg::TS_PTS_DTS, 33'h1_FFFF_0001, 33'h1_8000_4321,
                 24, 1'b0);
    build_packet(8'hC1, 2, 1'b0, pes_pkg::TS_PTS, 33'h0_5A5A_A5A5, 33'd0, 20, 1'b0);
    build_packet(8'hE2, 0, 1'b0, pes_pkg::TS_NONE, 33'd0, 33'd0, 18, 1'b0);
    build_packet(8'hC0, 1, 1'b1, pes_pkg::TS_PTS, 33'h1_0000_0000, 33'd0, 30, 1'b0);
    finish_test("5 back-pressure over 4 packets", err0);
    rand_mode = 1'b0;
  endtask

  task automatic test_bad_marker();
    int err0;
    err0 = errors;
    build_packet(8'hE3, 1, 1'b0, pes_pkg::TS_PTS, 33'h0_7654_3210, 33'd0, 11, 1'b1);
    finish_test("6 cleared pts marker bit", err0);
  endtask

  initial
  begin
    seed         = 32'h625d440a;
    in_data      = 8'h00;
    in_valid     = 1'b0;
    pay_ready    = 1'b0;
    rec_ready    = 1'b0;
    rand_mode    = 1'b0;
    gap          = 1'b0;
    in_taken     = 1'b0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    total_bytes  = 0;
    cycles       = 0;
    wait (rst == 1'b0);
    @(posedge read_signal);
    test_pts_with_std();
    test_pts_dts_stuffing();
    test_no_stamp();
    test_skip_other_streams();
    test_back_pressure();
    test_bad_marker();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

// File: sources.f
design/pes_pkg.sv
design/start_code_detector.sv
design/pes_header_parser.sv
design/time_stamp_parser.sv
design/sync_fifo.sv
design/pes_demux_top.sv
tests/clock_gen.sv
tests/pes_demux_asserts.sv
tests/pes_demux_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the pes demux testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module pes_demux_tb -o pes_demux_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/pes_demux_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Test OK$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
